/* hw/mips_pkg.sv */
package mips_pkg;

    ////////////////////////////////////////////////////////////////////
    // Basic types
    ////////////////////////////////////////////////////////////////////

    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        LUI
    } alu_op_e;

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;

    // R-type function codes
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_MOVZ = 6'h0a;
    localparam logic [5:0] FN_MOVN = 6'h0b;

    localparam data_t RESET_PC = 32'h0000_0000;

    ////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        data_t instr;
        data_t pc_4;
    } if_id_t;

    typedef struct packed {
        logic      nop;
        logic      reg_w;
        logic      branch;
        logic      branch_ne;
        logic      b_sel;
        logic      shamt_sel;
        logic      movz;
        logic      movn;
        alu_op_e   alu_op;
        logic [4:0] shamt;
        data_t     imm_ext;
        data_t     op_a;
        data_t     op_b;
        data_t     pc_4;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
    } id_ex_t;

    typedef struct packed {
        logic      reg_w;
        reg_addr_t rd_addr;
        data_t     result;
    } ex_wb_t;

    // Bubble values loaded on reset and flush
    localparam if_id_t IF_ID_BUBBLE = '{default: '0};
    localparam id_ex_t ID_EX_BUBBLE = '{nop: 1'b1, alu_op: ADD, default: '0};
    localparam ex_wb_t EX_WB_BUBBLE = '{default: '0};

endpackage

/* hw/pipe_reg.sv */
module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t bubble,
    input  payload_t d,
    output payload_t q
);

    // Stall wins over flush, so a stalled stage keeps its entry
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= bubble;
        end
        else if (!stall) begin
            if (flush) begin
                q <= bubble;
            end
            else begin
                q <= d;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    // Stage comes out of reset empty
    a_reset_bubble: assert property (
        @(posedge clk) !rst_n |=> (q == bubble)
    );

endmodule

/* hw/fetch_control.sv */
module fetch_control (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                use_rs,
    input  logic                use_rt,
    input  mips_pkg::reg_addr_t id_rs,
    input  mips_pkg::reg_addr_t id_rt,
    input  logic                ex_reg_w,
    input  mips_pkg::reg_addr_t ex_rd,
    input  logic                branch_taken,
    input  mips_pkg::data_t     branch_target,
    output mips_pkg::data_t     fetch_pc,
    output mips_pkg::data_t     pc_4,
    output logic                stall_if_id,
    output logic                flush_if_id,
    output logic                flush_id_ex
);
    import mips_pkg::*;

    data_t pc_q;
    logic  rs_hit;
    logic  rt_hit;
    logic  hazard;

    // RAW against the entry in execute only
    // The register file bypass covers writeback
    assign rs_hit = use_rs && (id_rs != '0) && (id_rs == ex_rd);
    assign rt_hit = use_rt && (id_rt != '0) && (id_rt == ex_rd);
    assign hazard = ex_reg_w && (rs_hit || rt_hit);

    // A branch in execute never writes, so it never meets a hazard
    assign stall_if_id = hazard;
    assign flush_if_id = branch_taken;
    assign flush_id_ex = hazard || branch_taken;

    assign fetch_pc = pc_q;
    assign pc_4     = pc_q + 32'd4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end
        else if (branch_taken) begin
            pc_q <= branch_target;
        end
        else if (!hazard) begin
            pc_q <= pc_4;
        end
    end

    a_no_stall_and_flush: assert property (
        @(posedge clk) disable iff (!rst_n) !(stall_if_id && flush_if_id)
    );

endmodule

/* hw/reg_file.sv */
module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  mips_pkg::reg_addr_t ra_addr,
    input  mips_pkg::reg_addr_t rb_addr,
    output mips_pkg::data_t     ra_data,
    output mips_pkg::data_t     rb_data,
    input  logic                w_en,
    input  mips_pkg::reg_addr_t w_addr,
    input  mips_pkg::data_t     w_data
);
    import mips_pkg::*;

    data_t regs [32];
    logic  wr;

    // No writes land while the core is held in reset
    assign wr = rst_n && w_en && (w_addr != '0);

    always_ff @(posedge clk) begin
        if (wr) begin
            regs[w_addr] <= w_data;
        end
    end

    // Same-cycle write is forwarded to decode
    function automatic data_t read_port(input reg_addr_t addr);
        if (addr == '0) return '0;
        if (wr && (w_addr == addr)) return w_data;
        return regs[addr];
    endfunction

    always_comb begin
        ra_data = read_port(ra_addr);
        rb_data = read_port(rb_addr);
    end

endmodule

/* hw/id_decode.sv */
module id_decode (
    input  mips_pkg::if_id_t    if_id,
    input  mips_pkg::data_t     ra_data,
    input  mips_pkg::data_t     rb_data,
    output mips_pkg::reg_addr_t ra_addr,
    output mips_pkg::reg_addr_t rb_addr,
    output logic                use_rs,
    output logic                use_rt,
    output mips_pkg::id_ex_t    id_ex
);
    import mips_pkg::*;

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;

    assign opcode = if_id.instr[31:26];
    assign rs     = if_id.instr[25:21];
    assign rt     = if_id.instr[20:16];
    assign rd     = if_id.instr[15:11];
    assign funct  = if_id.instr[5:0];
    assign imm    = if_id.instr[15:0];

    assign ra_addr = rs;
    assign rb_addr = rt;

    always_comb begin
        id_ex         = ID_EX_BUBBLE;
        id_ex.nop     = 1'b0;
        id_ex.shamt   = if_id.instr[10:6];
        id_ex.imm_ext = {{16{imm[15]}}, imm};
        id_ex.op_a    = ra_data;
        id_ex.op_b    = rb_data;
        id_ex.pc_4    = if_id.pc_4;
        id_ex.rs_addr = rs;
        id_ex.rt_addr = rt;
        use_rs        = 1'b0;
        use_rt        = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                id_ex.rd_addr = rd;
                id_ex.reg_w   = 1'b1;
                use_rs        = 1'b1;
                use_rt        = 1'b1;
                case (funct)
                    FN_ADDU: id_ex.alu_op = ADD;
                    FN_SUBU: id_ex.alu_op = SUB;
                    FN_AND:  id_ex.alu_op = AND;
                    FN_OR:   id_ex.alu_op = OR;
                    FN_XOR:  id_ex.alu_op = XOR;
                    FN_SLT:  id_ex.alu_op = SLT;
                    FN_MOVZ: id_ex.movz = 1'b1;
                    FN_MOVN: id_ex.movn = 1'b1;
                    FN_SLL, FN_SRL: begin
                        // Shifts take rt only, amount from the sa field
                        id_ex.alu_op    = (funct == FN_SLL) ? SLL : SRL;
                        id_ex.shamt_sel = 1'b1;
                        use_rs          = 1'b0;
                    end
                    default: begin
                        id_ex.nop   = 1'b1;
                        id_ex.reg_w = 1'b0;
                        use_rs      = 1'b0;
                        use_rt      = 1'b0;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI: begin
                id_ex.rd_addr = rt;
                id_ex.reg_w   = 1'b1;
                id_ex.b_sel   = 1'b1;
                use_rs        = (opcode != OP_LUI);
                // Logical immediates are zero extended
                if (opcode != OP_ADDIU) id_ex.imm_ext = {16'h0000, imm};
                if (opcode == OP_ADDIU) id_ex.alu_op = ADD;
                else if (opcode == OP_ORI) id_ex.alu_op = OR;
                else id_ex.alu_op = LUI;
            end
            OP_BEQ, OP_BNE: begin
                id_ex.branch    = 1'b1;
                id_ex.branch_ne = (opcode == OP_BNE);
                id_ex.alu_op    = SUB;
                use_rs          = 1'b1;
                use_rt          = 1'b1;
            end
            default: begin
                id_ex.nop = 1'b1;
            end
        endcase
    end

endmodule

/* hw/ex_alu.sv */
module ex_alu (
    input  mips_pkg::id_ex_t id_ex,
    output mips_pkg::ex_wb_t ex_wb,
    output logic             branch_taken,
    output mips_pkg::data_t  branch_target
);
    import mips_pkg::*;

    data_t      b_val;
    logic [4:0] sh_amt;
    data_t      alu_res;
    logic       b_zero;
    logic       move_ok;

    assign b_val  = id_ex.b_sel ? id_ex.imm_ext : id_ex.op_b;
    assign sh_amt = id_ex.shamt_sel ? id_ex.shamt : id_ex.op_a[4:0];
    assign b_zero = (id_ex.op_b == '0);

    ////////////////////////////////////////////////////////////////////
    // ALU and shifter
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (id_ex.alu_op)
            ADD:     alu_res = id_ex.op_a + b_val;
            SUB:     alu_res = id_ex.op_a - b_val;
            AND:     alu_res = id_ex.op_a & b_val;
            OR:      alu_res = id_ex.op_a | b_val;
            XOR:     alu_res = id_ex.op_a ^ b_val;
            SLT:     alu_res = {31'd0, $signed(id_ex.op_a) < $signed(b_val)};
            SLL:     alu_res = b_val << sh_amt;
            SRL:     alu_res = b_val >> sh_amt;
            LUI:     alu_res = {b_val[15:0], 16'h0000};
            default: alu_res = '0;
        endcase
    end

    // Conditional moves write rs only when the rt test passes
    assign move_ok = !(id_ex.movz && !b_zero) && !(id_ex.movn && b_zero);

    assign ex_wb.reg_w   = id_ex.reg_w && move_ok && (id_ex.rd_addr != '0);
    assign ex_wb.rd_addr = id_ex.rd_addr;
    assign ex_wb.result  = (id_ex.movz || id_ex.movn) ? id_ex.op_a : alu_res;

    ////////////////////////////////////////////////////////////////////
    // Branch resolution
    ////////////////////////////////////////////////////////////////////

    assign branch_taken  = id_ex.branch &&
                           ((id_ex.op_a == id_ex.op_b) != id_ex.branch_ne);
    assign branch_target = id_ex.pc_4 + {id_ex.imm_ext[29:0], 2'b00};

    // Bubbles must never redirect fetch
    always_comb begin
        a_bubble_no_branch: assert final (
            $isunknown(id_ex.nop) || !(branch_taken && id_ex.nop)
        );
    end

endmodule

/* hw/mips_core.sv */
module mips_core (
    input  logic                clk,
    input  logic                rst_n,
    output mips_pkg::data_t     fetch_pc,
    input  mips_pkg::data_t     fetch_instr,
    output logic                wb_valid,
    output mips_pkg::reg_addr_t wb_addr,
    output mips_pkg::data_t     wb_data
);
    import mips_pkg::*;

    data_t     pc_4;
    logic      stall_if_id;
    logic      flush_if_id;
    logic      flush_id_ex;
    logic      use_rs;
    logic      use_rt;
    reg_addr_t ra_addr;
    reg_addr_t rb_addr;
    data_t     ra_data;
    data_t     rb_data;
    logic      branch_taken;
    data_t     branch_target;
    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_wb_t    ex_wb_d;
    ex_wb_t    ex_wb_q;

    assign if_id_d = '{instr: fetch_instr, pc_4: pc_4};

    fetch_control u_fetch (
        .clk(clk), .rst_n(rst_n), .use_rs(use_rs), .use_rt(use_rt),
        .id_rs(ra_addr), .id_rt(rb_addr),
        .ex_reg_w(id_ex_q.reg_w), .ex_rd(id_ex_q.rd_addr),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .fetch_pc(fetch_pc), .pc_4(pc_4), .stall_if_id(stall_if_id),
        .flush_if_id(flush_if_id), .flush_id_ex(flush_id_ex)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .rst_n(rst_n), .stall(stall_if_id), .flush(flush_if_id),
        .bubble(IF_ID_BUBBLE), .d(if_id_d), .q(if_id_q)
    );

    reg_file u_rf (
        .clk(clk), .rst_n(rst_n), .ra_addr(ra_addr), .rb_addr(rb_addr),
        .ra_data(ra_data), .rb_data(rb_data), .w_en(ex_wb_q.reg_w),
        .w_addr(ex_wb_q.rd_addr), .w_data(ex_wb_q.result)
    );

    id_decode u_decode (
        .if_id(if_id_q), .ra_data(ra_data), .rb_data(rb_data), .ra_addr(ra_addr),
        .rb_addr(rb_addr), .use_rs(use_rs), .use_rt(use_rt), .id_ex(id_ex_d)
    );

    // ID/EX never stalls, a hazard turns into a bubble here
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(flush_id_ex),
        .bubble(ID_EX_BUBBLE), .d(id_ex_d), .q(id_ex_q)
    );

    ex_alu u_ex (
        .id_ex(id_ex_q), .ex_wb(ex_wb_d),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .clk(clk), .rst_n(rst_n), .stall(1'b0), .flush(1'b0),
        .bubble(EX_WB_BUBBLE), .d(ex_wb_d), .q(ex_wb_q)
    );

    assign wb_valid = ex_wb_q.reg_w;
    assign wb_addr  = ex_wb_q.rd_addr;
    assign wb_data  = ex_wb_q.result;

endmodule

/* verif/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    // Free running, first rising edge at half a period
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

/* verif/mips_core_tb.sv */
module mips_core_tb;
    import mips_pkg::*;

    localparam int MEM_WORDS      = 64;
    localparam int RESET_CYCLES   = 10;
    localparam int IDLE_CYCLES    = 8;
    localparam int TIMEOUT_CYCLES = 5 * (MEM_WORDS * 3 + 20);

    // One expected register write
    typedef struct packed {
        reg_addr_t addr;
        data_t     data;
    } wb_exp_t;

    logic      clk;
    logic      rst_n;
    data_t     fetch_pc;
    data_t     fetch_instr;
    logic      wb_valid;
    reg_addr_t wb_addr;
    data_t     wb_data;

    data_t   imem [MEM_WORDS];
    int      prog_len    = 0;
    wb_exp_t exp_q [$];
    int      cycle_count = 0;
    int      error_count = 0;
    int      check_count = 0;
    int      test_count  = 0;

    tb_clk_gen #(.PERIOD(100)) u_clk (.clk(clk));

    mips_core dut_i (
        .clk(clk), .rst_n(rst_n), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data)
    );

    // Instruction memory, anything past it reads as sll r0
    always_comb begin
        if (fetch_pc < MEM_WORDS * 4) begin
            fetch_instr = imem[fetch_pc[7:2]];
        end
        else begin
            fetch_instr = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Program building
    //////////////////////////////////////////////////////////////////////

    function automatic data_t enc_r(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                    reg_addr_t rd, logic [4:0] sa);
        return {OP_RTYPE, rs, rt, rd, sa, fn};
    endfunction

    function automatic data_t enc_i(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(7, 0));
    endfunction

    function automatic logic [5:0] pick_alu_fn();
        case ($urandom_range(7, 0))
            0: return FN_ADDU;
            1: return FN_SUBU;
            2: return FN_AND;
            3: return FN_OR;
            4: return FN_XOR;
            5: return FN_SLT;
            6: return FN_SLL;
            default: return FN_SRL;
        endcase
    endfunction

    // Shifts only read rt, so a dependency always goes through rt
    function automatic data_t random_alu(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
        logic [5:0] fn;
        fn = pick_alu_fn();
        if (fn == FN_SLL || fn == FN_SRL) begin
            return enc_r(fn, 5'd0, rt, rd, 5'($urandom()));
        end
        return enc_r(fn, rs, rt, rd, 5'd0);
    endfunction

    task automatic emit(input data_t ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic clear_program();
        foreach (imem[i]) imem[i] = '0;
        prog_len = 0;
    endtask

    // Gives r1..r7 known values through addiu or a lui/ori pair
    task automatic load_registers();
        for (int r = 1; r < 8; r++) begin
            if ($urandom_range(1, 0) == 1) begin
                emit(enc_i(OP_LUI, 5'd0, reg_addr_t'(r), 16'($urandom())));
                emit(enc_i(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), 16'($urandom())));
            end
            else begin
                emit(enc_i(OP_ADDIU, 5'd0, reg_addr_t'(r), 16'($urandom())));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic void run_model();
        data_t     regs [32];
        data_t     ins;
        data_t     a;
        data_t     b;
        data_t     res;
        logic      wr;
        reg_addr_t rd;
        wb_exp_t   e;
        int        pc;
        exp_q.delete();
        foreach (regs[i]) regs[i] = '0;
        pc = 0;
        while (pc < prog_len) begin
            ins = imem[pc];
            a   = regs[ins[25:21]];
            b   = regs[ins[20:16]];
            rd  = ins[15:11];
            res = '0;
            wr  = 1'b1;
            pc++;
            case (ins[31:26])
                OP_RTYPE: begin
                    case (ins[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << ins[10:6];
                        FN_SRL:  res = b >> ins[10:6];
                        FN_MOVZ: begin
                            res = a;
                            wr  = (b == '0);
                        end
                        FN_MOVN: begin
                            res = a;
                            wr  = (b != '0);
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin
                    rd  = ins[20:16];
                    res = a + {{16{ins[15]}}, ins[15:0]};
                end
                OP_ORI: begin
                    rd  = ins[20:16];
                    res = a | {16'h0000, ins[15:0]};
                end
                OP_LUI: begin
                    rd  = ins[20:16];
                    res = {ins[15:0], 16'h0000};
                end
                OP_BEQ, OP_BNE: begin
                    wr = 1'b0;
                    // No delay slot, the taken path skips straight to the target
                    if ((a == b) == (ins[31:26] == OP_BEQ)) begin
                        pc += int'($signed(ins[15:0]));
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && rd != '0) begin
                regs[rd] = res;
                e.addr   = rd;
                e.data   = res;
                exp_q.push_back(e);
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Cycle stepping and checking
    //////////////////////////////////////////////////////////////////////

    // Outputs are sampled on the falling edge, inputs change right after
    task automatic step_cycle();
        wb_exp_t e;
        @(negedge clk);
        cycle_count++;
        if (wb_valid === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                $display("Unexpected write of %08h to r%0d at time %0t with no write pending",
                         wb_data, wb_addr, $time);
                error_count++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                check_count++;
                assert (wb_addr == e.addr) else begin
                    $display("[ERROR] %0t wb_addr expected %0d got %0d", $time, e.addr, wb_addr);
                    error_count++;
                end
                assert (wb_data == e.data) else begin
                    $display("[ERROR] %0t wb_data expected %08h got %08h",
                             $time, e.data, wb_data);
                    error_count++;
                end
            end
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            step_cycle();
            assert (wb_valid == 1'b0) else begin
                $display("[ERROR] %0t wb_valid expected 0 got %0b", $time, wb_valid);
                error_count++;
            end
            assert (fetch_pc == RESET_PC) else begin
                $display("[ERROR] %0t fetch_pc expected %08h got %08h", $time, RESET_PC, fetch_pc);
                error_count++;
            end
        end
        rst_n = 1'b1;
    endtask

    // Runs the loaded program until every write is seen and the core goes quiet
    task automatic run_test(input string name);
        int errors_before;
        int checks_before;
        int idle;
        errors_before = error_count;
        checks_before = check_count;
        test_count++;
        run_model();
        apply_reset();
        idle = 0;
        while (idle < IDLE_CYCLES) begin
            step_cycle();
            if (exp_q.size() == 0 && wb_valid !== 1'b1) begin
                idle++;
            end
            else begin
                idle = 0;
            end
        end
        $display("Test %0d %s: %0d writes checked, %0d errors", test_count, name,
                 check_count - checks_before, error_count - errors_before);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    initial begin
        reg_addr_t dst [$];
        reg_addr_t src;
        reg_addr_t cond;
        logic [5:0] op;
        void'($urandom(32'h8be0cf58));
        rst_n = 1'b0;
        clear_program();

        run_test("reset state");

        clear_program();
        load_registers();
        repeat (30) emit(random_alu(rand_reg(), rand_reg(), rand_reg()));
        run_test("random alu and shift");

        // Distances 1, 2 and 3 back to the producer
        clear_program();
        load_registers();
        for (int k = 0; k < 30; k++) begin
            src = (dst.size() >= k % 3 + 1) ? dst[dst.size() - (k % 3 + 1)] : rand_reg();
            dst.push_back(reg_addr_t'($urandom_range(7, 1)));
            emit(random_alu(rand_reg(), src, dst[dst.size() - 1]));
        end
        run_test("dependent chains");

        clear_program();
        load_registers();
        repeat (18) begin
            cond = reg_addr_t'($urandom_range(7, 1));
            if ($urandom_range(1, 0) == 1) begin
                emit(enc_i(OP_ADDIU, 5'd0, cond, 16'h0000));
            end
            else begin
                emit(enc_i(OP_ADDIU, 5'd0, cond, 16'($urandom_range(16'hffff, 1))));
            end
            op = ($urandom_range(1, 0) == 1) ? FN_MOVZ : FN_MOVN;
            emit(enc_r(op, rand_reg(), cond, rand_reg(), 5'd0));
        end
        run_test("conditional moves");

        // Comparing a register with itself makes beq taken and bne untaken
        clear_program();
        load_registers();
        repeat (24) begin
            if ($urandom_range(2, 0) == 0) begin
                op   = ($urandom_range(1, 0) == 1) ? OP_BEQ : OP_BNE;
                src  = rand_reg();
                cond = ($urandom_range(1, 0) == 1) ? src : rand_reg();
                emit(enc_i(op, src, cond, 16'($urandom_range(3, 0))));
            end
            else begin
                emit(random_alu(rand_reg(), rand_reg(), rand_reg()));
            end
        end
        run_test("forward branches");

        $display("Ran %0d tests, checked %0d writes, %0d errors in %0d cycles",
                 test_count, check_count, error_count, cycle_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog on the cycle count
    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* tb.f */
hw/mips_pkg.sv
hw/pipe_reg.sv
hw/fetch_control.sv
hw/reg_file.sv
hw/id_decode.sv
hw/ex_alu.sv
hw/mips_core.sv
verif/tb_clk_gen.sv
verif/mips_core_tb.sv

/* Bender.yml */
package:
  name: mips_pipe_slice

sources:
  - target: rtl
    files:
      - hw/mips_pkg.sv
      - hw/pipe_reg.sv
      - hw/fetch_control.sv
      - hw/reg_file.sv
      - hw/id_decode.sv
      - hw/ex_alu.sv
      - hw/mips_core.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/mips_core_tb.sv
